// ==== include/l2w_settings.svh ====
`ifndef L2W_SETTINGS_SVH
`define L2W_SETTINGS_SVH

// memory port address and data widths
`define L2W_ADDR_W 32
`define L2W_DATA_W 32

// log2 of words per cache line
`define L2W_OFFSET_W 2

// words per line
`define L2W_LINE_WORDS (1 << `L2W_OFFSET_W)

`endif

// ==== source/l2w_pkg.sv ====
`include "l2w_settings.svh"

package l2w_pkg;

    // one cache line, word 0 in the low bits
    typedef logic [`L2W_LINE_WORDS*`L2W_DATA_W-1:0] line_t;

    typedef enum logic [2:0] {
        ARB_IDLE, // buffer owns the channel
        ARB_LINE, // line handed to buffer
        UNC_AW,
        UNC_W,
        UNC_B
    } arb_state_e;

    typedef enum logic [1:0] {
        BUF_EMPTY,
        BUF_AW,
        BUF_W,
        BUF_B
    } buf_state_e;

endpackage

// ==== source/l2w_axi_if.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

interface l2w_axi_if;

    logic [`L2W_ADDR_W-1:0]   awaddr;
    logic [7:0]               awlen;
    logic                     awvalid;
    logic                     awready;
    logic [`L2W_DATA_W-1:0]   wdata;
    logic [`L2W_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wlast;
    logic                     wready;
    logic                     bvalid;
    logic                     bready;

    modport master (
        output awaddr, awlen, awvalid, wdata, wstrb, wvalid, wlast, bready,
        input  awready, wready, bvalid
    );

    modport slave (
        input  awaddr, awlen, awvalid, wdata, wstrb, wvalid, wlast, bready,
        output awready, wready, bvalid
    );

endinterface

// ==== source/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             clear,
    input  logic             step,
    input  logic [width-1:0] last_beat,
    output logic [width-1:0] count,
    output logic             last
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (clear) begin
            count <= '0; // new burst
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // high for the whole final beat, even while it stalls
    assign last = (count == last_beat);

endmodule

// ==== source/write_buffer.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

module write_buffer
    import l2w_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load,
    input  logic [`L2W_ADDR_W-1:0] addr,
    input  line_t                  line,
    output logic                   busy,
    l2w_axi_if.master              axi
);

    localparam int lo_w = `L2W_OFFSET_W + $clog2(`L2W_DATA_W / 8); // line offset in bytes
    localparam logic [`L2W_OFFSET_W-1:0] last_idx = `L2W_OFFSET_W'(`L2W_LINE_WORDS - 1);

    buf_state_e                state;
    buf_state_e                state_nxt;
    logic [`L2W_ADDR_W-1:0]    addr_q;
    line_t                     line_q;
    logic [`L2W_OFFSET_W-1:0]  beat;
    logic                      beat_last;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= BUF_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= {addr[`L2W_ADDR_W-1:lo_w], {lo_w{1'b0}}}; // line aligned
            line_q <= line;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            BUF_EMPTY: if (load) state_nxt = BUF_AW;
            BUF_AW:    if (axi.awready) state_nxt = BUF_W;
            BUF_W:     if (axi.wready && beat_last) state_nxt = BUF_B;
            BUF_B:     if (axi.bvalid) state_nxt = BUF_EMPTY;
            default:   state_nxt = BUF_EMPTY;
        endcase
    end

    beat_counter #(
        .width(`L2W_OFFSET_W)
    ) beat_counter_i (
        .clk      (clk),
        .rstn     (rstn),
        .clear    (load),
        .step     (state == BUF_W && axi.wready),
        .last_beat(last_idx),
        .count    (beat),
        .last     (beat_last)
    );

    assign busy        = (state != BUF_EMPTY);
    assign axi.awaddr  = addr_q;
    assign axi.awlen   = 8'(`L2W_LINE_WORDS - 1);
    assign axi.awvalid = (state == BUF_AW);
    assign axi.wdata   = line_q[beat*`L2W_DATA_W +: `L2W_DATA_W];
    assign axi.wstrb   = '1; // full words only
    assign axi.wvalid  = (state == BUF_W);
    assign axi.wlast   = (state == BUF_W) && beat_last;
    assign axi.bready  = (state == BUF_B);

endmodule

// ==== source/write_arbiter.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

module write_arbiter
    import l2w_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req,
    input  logic                     uncached,
    input  logic [`L2W_ADDR_W-1:0]   addr,
    input  line_t                    line,
    input  logic [`L2W_DATA_W/8-1:0] strb,
    input  logic                     buf_busy,
    output logic                     addr_ok,
    output logic                     buf_load,
    output logic                     unc_lock,
    l2w_axi_if.slave                 buf_axi,
    output logic [`L2W_ADDR_W-1:0]   awaddr,
    output logic [7:0]               awlen,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`L2W_DATA_W-1:0]   wdata,
    output logic [`L2W_DATA_W/8-1:0] wstrb,
    output logic                     wvalid,
    output logic                     wlast,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);

    arb_state_e state;
    arb_state_e state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // both kinds wait for an empty buffer, keeps writes in order
    always_comb begin
        state_nxt = state;
        unique case (state)
            ARB_IDLE: begin
                if (req && !buf_busy) begin
                    state_nxt = uncached ? UNC_AW : ARB_LINE;
                end
            end
            ARB_LINE: state_nxt = ARB_IDLE; // one cycle load
            UNC_AW:   if (awready) state_nxt = UNC_W;
            UNC_W:    if (wready) state_nxt = UNC_B;
            UNC_B:    if (bvalid) state_nxt = ARB_IDLE;
            default:  state_nxt = ARB_IDLE;
        endcase
    end

    always_comb begin
        // buffer channel straight through by default
        awaddr          = buf_axi.awaddr;
        awlen           = buf_axi.awlen;
        awvalid         = buf_axi.awvalid;
        wdata           = buf_axi.wdata;
        wstrb           = buf_axi.wstrb;
        wvalid          = buf_axi.wvalid;
        wlast           = buf_axi.wlast;
        bready          = buf_axi.bready;
        buf_axi.awready = awready;
        buf_axi.wready  = wready;
        buf_axi.bvalid  = bvalid;
        addr_ok         = 1'b0;
        buf_load        = 1'b0;
        unc_lock        = 1'b0;

        unique case (state)
            ARB_LINE: begin
                buf_load = 1'b1;
                addr_ok  = 1'b1;
            end
            UNC_AW, UNC_W, UNC_B: begin
                buf_axi.awready = 1'b0; // buffer is idle here
                buf_axi.wready  = 1'b0;
                buf_axi.bvalid  = 1'b0;
                unc_lock        = 1'b1;
                awaddr          = addr;
                awlen           = 8'd0; // single beat
                awvalid         = (state == UNC_AW);
                wdata           = line[`L2W_DATA_W-1:0];
                wstrb           = strb;
                wvalid          = (state == UNC_W);
                wlast           = (state == UNC_W);
                bready          = (state == UNC_B);
                addr_ok         = (state == UNC_B) && bvalid; // ack only after B
            end
            default: ;
        endcase
    end

endmodule

// ==== source/l2_write_path.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

module l2_write_path
    import l2w_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req,
    input  logic                     uncached,
    input  logic [`L2W_ADDR_W-1:0]   addr,
    input  line_t                    line,
    input  logic [`L2W_DATA_W/8-1:0] strb,
    output logic                     addr_ok,
    output logic                     unc_lock,
    output logic [`L2W_ADDR_W-1:0]   awaddr,
    output logic [7:0]               awlen,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`L2W_DATA_W-1:0]   wdata,
    output logic [`L2W_DATA_W/8-1:0] wstrb,
    output logic                     wvalid,
    output logic                     wlast,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);

    logic buf_load;
    logic buf_busy;

    l2w_axi_if buf_axi_if ();

    write_buffer write_buffer_i (
        .clk (clk),
        .rstn(rstn),
        .load(buf_load),
        .addr(addr),
        .line(line),
        .busy(buf_busy),
        .axi (buf_axi_if.master)
    );

    write_arbiter write_arbiter_i (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .uncached(uncached),
        .addr    (addr),
        .line    (line),
        .strb    (strb),
        .buf_busy(buf_busy),
        .addr_ok (addr_ok),
        .buf_load(buf_load),
        .unc_lock(unc_lock),
        .buf_axi (buf_axi_if.slave),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== verification/axi_slave_model.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

module axi_slave_model (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`L2W_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`L2W_DATA_W-1:0]   wdata,
    input  logic [`L2W_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    input  logic                     wlast,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready
);

    logic [`L2W_DATA_W-1:0] mem [16]; // 64 bytes of word memory
    logic [31:0]            lcg_state;
    logic                   aw_open;
    logic                   b_due;
    logic [3:0]             aw_idx;
    logic [3:0]             beat;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        lcg_state = 32'd62;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507); // depends on full index
        end
    end

    // ready and response outputs change on the falling edge
    always @(negedge clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            lcg_state <= next_rand(lcg_state);
            awready   <= !aw_open && !b_due && (lcg_state[17:16] != 2'b00);
            wready    <= aw_open && (lcg_state[20:19] != 2'b00);
            bvalid    <= b_due && (bvalid || lcg_state[23]); // held until bready
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aw_open <= 1'b0;
            b_due   <= 1'b0;
            aw_idx  <= '0;
            beat    <= '0;
        end else begin
            if (awvalid && awready) begin
                aw_open <= 1'b1;
                aw_idx  <= awaddr[5:2];
                beat    <= '0;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < `L2W_DATA_W / 8; b++) begin
                    if (wstrb[b]) mem[aw_idx + beat][8*b +: 8] <= wdata[8*b +: 8];
                end
                beat <= beat + 1'b1;
                if (wlast) begin
                    aw_open <= 1'b0;
                    b_due   <= 1'b1;
                end
            end
            if (bvalid && bready) b_due <= 1'b0;
        end
    end

endmodule

// ==== verification/tb_l2_write_path.sv ====
`timescale 1ns/1ps
`include "l2w_settings.svh"

module tb_l2_write_path
    import l2w_pkg::*;
();

    localparam int n_requests = 49; // 2 + 3 + 4 + 40
    localparam int line_bytes = `L2W_LINE_WORDS * (`L2W_DATA_W / 8);

    logic clk, rstn, req, uncached, addr_ok, unc_lock;
    logic [`L2W_ADDR_W-1:0]   addr, awaddr;
    line_t                    line;
    logic [`L2W_DATA_W/8-1:0] strb, wstrb;
    logic [7:0]               awlen;
    logic                     awvalid, awready, wvalid, wlast, wready, bvalid, bready;
    logic [`L2W_DATA_W-1:0]   wdata;

    logic [`L2W_DATA_W-1:0]   ref_mem [16];
    logic [`L2W_ADDR_W-1:0]   exp_addr [$];
    logic [7:0]               exp_len [$];
    logic [3:0]               exp_strb [$];
    line_t                    exp_line [$];
    logic [`L2W_ADDR_W-1:0]   cur_addr;
    logic [7:0]               cur_len;
    logic [3:0]               cur_strb;
    line_t                    cur_line;
    int                       beat;
    int                       pending;
    logic                     idle_phase;
    logic                     line_open;
    logic [31:0]              rand_state;
    string                    test_name;

    tb_clock clock_gen_i (.clk(clk), .rstn(rstn));

    l2_write_path l2_write_path_i (.*);

    axi_slave_model slave_i (.*);

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_error(input string name, input logic [127:0] exp, act);
        $display("** FAIL **");
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        $fatal(1);
    endtask

    task automatic stop_with_reason(input string what);
        $display("** FAIL **");
        $display("%s: %s", test_name, what);
        $fatal(1);
    endtask

    // push the expected bus transfer and apply it to the reference memory
    task automatic issue_request(input logic unc, input logic [`L2W_ADDR_W-1:0] a,
                                 input line_t l, input logic [3:0] s);
        int base;
        base = a[5:4] * `L2W_LINE_WORDS;
        idle_phase = 1'b0;
        pending++;
        exp_addr.push_back(unc ? a : a & ~(line_bytes - 1));
        exp_len.push_back(unc ? 8'd0 : 8'(`L2W_LINE_WORDS - 1));
        exp_strb.push_back(unc ? s : 4'hf);
        exp_line.push_back(l);
        if (unc) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) ref_mem[a[5:2]][8*b +: 8] = l[8*b +: 8];
            end
        end else begin
            for (int k = 0; k < `L2W_LINE_WORDS; k++) begin
                ref_mem[base + k] = l[k*`L2W_DATA_W +: `L2W_DATA_W];
            end
        end
        req      = 1'b1;
        uncached = unc;
        addr     = a;
        line     = l;
        strb     = s;
        do @(posedge clk); while (!addr_ok);
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic random_request(input logic unc);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            rand_state = next_rand(rand_state);
            l[32*k +: 32] = rand_state;
        end
        rand_state = next_rand(rand_state);
        issue_request(unc, {26'd0, rand_state[19:16], 2'b00}, l, rand_state[27:24]);
    endtask

    task automatic drain_and_compare();
        while (pending != 0) @(negedge clk);
        for (int i = 0; i < 16; i++) begin
            assert (slave_i.mem[i] == ref_mem[i])
                else report_error({test_name, " memory"}, ref_mem[i], slave_i.mem[i]);
        end
    endtask

    // bus monitor checks every transfer in issue order
    always @(posedge clk) begin
        if (rstn) begin
            if (awvalid && awready) begin
                if (exp_addr.size() == 0) stop_with_reason("AW handshake with no request open");
                cur_addr = exp_addr.pop_front();
                cur_len  = exp_len.pop_front();
                cur_strb = exp_strb.pop_front();
                cur_line = exp_line.pop_front();
                beat     = 0;
                assert (awaddr == cur_addr) else report_error(test_name, cur_addr, awaddr);
                assert (awlen == cur_len) else report_error(test_name, cur_len, awlen);
            end
            if (wvalid && wready) begin
                assert (wdata == cur_line[beat*32 +: 32])
                    else report_error(test_name, cur_line[beat*32 +: 32], wdata);
                assert (wstrb == cur_strb) else report_error(test_name, cur_strb, wstrb);
                assert (wlast == (beat == cur_len))
                    else report_error(test_name, beat == cur_len, wlast);
                beat++;
            end
            if (bvalid && bready) begin
                pending--;
                if (!unc_lock) line_open <= 1'b0;
            end
            if (addr_ok && !unc_lock) line_open <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        idle_phase |-> !awvalid && !wvalid && !bready && !addr_ok && !unc_lock)
        else stop_with_reason("channel active before the first request");
    assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else stop_with_reason("AW payload changed while stalled");
    assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
        else stop_with_reason("W payload changed while stalled");
    assert property (@(posedge clk) disable iff (!rstn)
        addr_ok && unc_lock |-> bvalid && bready)
        else stop_with_reason("uncached addr_ok before the B response");
    assert property (@(posedge clk) disable iff (!rstn) awvalid && awlen == 0 |-> unc_lock)
        else stop_with_reason("unc_lock low during uncached AW");
    assert property (@(posedge clk) disable iff (!rstn) unc_lock && !addr_ok |=> unc_lock)
        else stop_with_reason("unc_lock dropped before addr_ok");
    assert property (@(posedge clk) disable iff (!rstn) unc_lock && awvalid |-> !line_open)
        else stop_with_reason("uncached AW overtook an open line write");

    initial begin
        repeat (n_requests * 200) @(posedge clk);
        $display("** FAIL **");
        $display("timeout: requests did not complete in time");
        $fatal(1);
    end

    initial begin
        req        = 1'b0;
        uncached   = 1'b0;
        addr       = '0;
        line       = '0;
        strb       = '0;
        pending    = 0;
        beat       = 0;
        idle_phase = 1'b1;
        line_open  = 1'b0;
        rand_state = 32'd62;
        test_name  = "reset";
        @(posedge rstn);
        repeat (4) @(negedge clk); // quiet bus checked here
        for (int i = 0; i < 16; i++) ref_mem[i] = slave_i.mem[i];

        test_name = "line_write";
        issue_request(1'b0, 32'h14, {32'h33333333, 32'h22222222, 32'h11111111, 32'h00000000},
                      4'h0);
        issue_request(1'b0, 32'h28, {32'hdddd0003, 32'hcccc0002, 32'hbbbb0001, 32'haaaa0000},
                      4'h0);
        drain_and_compare();

        test_name = "uncached_write";
        issue_request(1'b1, 32'h14, {96'd0, 32'hfeedbeef}, 4'b0101);
        issue_request(1'b1, 32'h30, {96'd0, 32'h12345678}, 4'b1111);
        issue_request(1'b1, 32'h08, {96'd0, 32'hcafef00d}, 4'b1000);
        drain_and_compare();

        test_name = "line_then_uncached";
        issue_request(1'b0, 32'h34, {32'h0d0d0d0d, 32'h0c0c0c0c, 32'h0b0b0b0b, 32'h0a0a0a0a},
                      4'h0);
        issue_request(1'b1, 32'h38, {96'd0, 32'h99887766}, 4'b0011);
        issue_request(1'b0, 32'h00, {32'h40404040, 32'h30303030, 32'h20202020, 32'h10101010},
                      4'h0);
        issue_request(1'b1, 32'h00, {96'd0, 32'h5555aaaa}, 4'b1100);
        drain_and_compare();

        test_name = "random_mix";
        for (int n = 0; n < 40; n++) begin
            rand_state = next_rand(rand_state);
            random_request(rand_state[12]);
        end
        drain_and_compare();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/l2w_pkg.sv
source/l2w_axi_if.sv
source/beat_counter.sv
source/write_buffer.sv
source/write_arbiter.sv
source/l2_write_path.sv
verification/tb_clock.sv
verification/axi_slave_model.sv
verification/tb_l2_write_path.sv

// ==== Makefile ====
# Verilator build and run for the L2 write path testbench

VERILATOR ?= verilator
TOP       ?= tb_l2_write_path
RTL_TOP   ?= l2_write_path
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
